/* Makefile */
# Verilator flow for the trajectory stepper.

TOP := tb_flight_path
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)
	verilator --lint-only --assert -f all.f \
		source/flight_path_top.sv --top-module flight_path_top

obj_dir/V$(TOP): all.f
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
+incdir+tb
source/flight_pkg.sv
source/sine_lookup.sv
source/altitude_calculator.sv
source/trajectory_integrator.sv
source/flight_path_top.sv
tb/tb_flight_path.sv

/* source/altitude_calculator.sv */
`default_nettype none

module altitude_calculator (
    input  logic                                    clk,
    input  logic                                    resetb,
    input  logic                                    launch,
    input  flight_pkg::step_t                       step,
    input  logic                                    step_valid,
    input  logic                                    step_ready,
    output logic [flight_pkg::table_depth_log2-1:0] sin_index,
    output logic [flight_pkg::table_depth_log2-1:0] cos_index,
    input  logic [flight_pkg::table_w-1:0]          sin_value,
    input  logic [flight_pkg::table_w-1:0]          cos_value,
    output flight_pkg::increment_t                  increment,
    output logic                                    increment_valid
);

    import flight_pkg::*;

    // Two guard bits keep the pitch update free of wrap.
    localparam int wide_w = pitch_w + 2;
    localparam logic [table_depth_log2-1:0] index_last = table_depth_log2'(table_depth - 1);

    logic                        accept;
    logic signed [wide_w-1:0]    pitch_base;
    logic signed [wide_w-1:0]    rate_wide;
    logic signed [wide_w-1:0]    pitch_wide;
    logic [pitch_w-1:0]          pitch_next;

    // Stage 1 holds the running pitch, which also addresses the table.
    logic [pitch_w-1:0]          pitch_q;
    logic [velocity_w-1:0]       s1_velocity;
    logic                        s1_valid;

    // Stage 2 lines up with the registered table outputs.
    logic [velocity_w-1:0]       s2_velocity;
    logic [pitch_w-1:0]          s2_pitch;
    logic                        s2_valid;

    logic [product_w-1:0]        dz_product;
    logic [product_w-1:0]        dx_product;

    // Nothing enters during a launch pulse.
    assign accept = step_valid && step_ready && !launch;

    assign pitch_base = {2'b00, pitch_q};
    assign rate_wide = {{(wide_w - rate_w){step.pitch_rate[rate_w-1]}}, step.pitch_rate};
    assign pitch_wide = pitch_base - rate_wide;

    // The top bit flags a negative pitch, the next one a pitch past full scale.
    always_comb begin
        if (pitch_wide[wide_w-1]) begin
            pitch_next = '0;
        end else if (pitch_wide[wide_w-2]) begin
            pitch_next = pitch_max;
        end else begin
            pitch_next = pitch_wide[pitch_w-1:0];
        end
    end

    // Cosine is the sine read from the mirrored bin.
    assign sin_index = pitch_q[pitch_w-1 -: table_depth_log2];
    assign cos_index = index_last - sin_index;

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            pitch_q <= initial_pitch;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            increment_valid <= 1'b0;
        end else if (launch) begin
            pitch_q <= initial_pitch;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            increment_valid <= 1'b0;
        end else begin
            if (accept) begin
                pitch_q <= pitch_next;
            end
            s1_valid <= accept;
            s2_valid <= s1_valid;
            increment_valid <= s2_valid;
        end
    end

    assign dz_product = s2_velocity * sin_value;
    assign dx_product = s2_velocity * cos_value;

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_velocity <= step.velocity;
        end
        s2_velocity <= s1_velocity;
        s2_pitch <= pitch_q;
        increment.dz <= dz_product[product_w-1:table_scale_shift];
        increment.dx <= dx_product[product_w-1:table_scale_shift];
        increment.pitch <= s2_pitch;
    end

    assert property (@(posedge clk) disable iff (!resetb)
        !$isunknown(pitch_q))
        else $error("altitude_calculator: pitch unknown");

    // Clamping keeps each update on the side the rate points to.
    assert property (@(posedge clk) disable iff (!resetb)
        accept && !step.pitch_rate[rate_w-1] |=> pitch_q <= $past(pitch_q))
        else $error("altitude_calculator: pitch rose on a positive rate");

    assert property (@(posedge clk) disable iff (!resetb)
        accept && step.pitch_rate[rate_w-1] |=> pitch_q >= $past(pitch_q))
        else $error("altitude_calculator: pitch fell on a negative rate");

endmodule

`default_nettype wire

/* source/flight_path_top.sv */
`default_nettype none

module flight_path_top (
    input  logic                clk,
    input  logic                resetb,
    input  logic                launch,
    input  flight_pkg::step_t   step,
    input  logic                step_valid,
    output logic                step_ready,
    output flight_pkg::result_t result,
    output logic                result_valid
);

    import flight_pkg::*;

    logic [table_depth_log2-1:0] sin_index;
    logic [table_depth_log2-1:0] cos_index;
    logic [table_w-1:0]          sin_value;
    logic [table_w-1:0]          cos_value;
    increment_t                  increment;
    logic                        increment_valid;

    // Pitch update, table addressing and speed resolution.
    altitude_calculator u_calculator (
        .clk             (clk),
        .resetb          (resetb),
        .launch          (launch),
        .step            (step),
        .step_valid      (step_valid),
        .step_ready      (step_ready),
        .sin_index       (sin_index),
        .cos_index       (cos_index),
        .sin_value       (sin_value),
        .cos_value       (cos_value),
        .increment       (increment),
        .increment_valid (increment_valid)
    );

    sine_lookup u_lookup (
        .clk       (clk),
        .sin_index (sin_index),
        .cos_index (cos_index),
        .sin_value (sin_value),
        .cos_value (cos_value)
    );

    // Position sums and the target cutoff.
    trajectory_integrator u_integrator (
        .clk             (clk),
        .resetb          (resetb),
        .launch          (launch),
        .increment       (increment),
        .increment_valid (increment_valid),
        .step_ready      (step_ready),
        .result          (result),
        .result_valid    (result_valid)
    );

endmodule

`default_nettype wire

/* source/flight_pkg.sv */
`default_nettype none

package flight_pkg;

    // Fixed-point widths.
    localparam int velocity_w = 16;
    localparam int pitch_w = 14;
    localparam int rate_w = 14;
    localparam int pos_w = 32;
    localparam int table_w = 16;
    localparam int table_depth_log2 = 6;
    localparam int table_depth = 1 << table_depth_log2;

    // Entries hold sine scaled by 32767, so products drop 15 bits.
    localparam int table_scale_shift = 15;
    localparam int product_w = velocity_w + table_w;
    localparam int increment_w = product_w - table_scale_shift;

    // Pitch 0 is horizontal, full scale is vertical.
    localparam logic [pitch_w-1:0] initial_pitch = 14'd10923;
    localparam logic [pitch_w-1:0] pitch_max = 14'd16383;

    // Altitude in metres at which the flight ends.
    localparam logic [pos_w-1:0] target_altitude = 32'd188000;

    // Quarter-wave table image, read relative to the project root.
    localparam string sine_file = "source/sine_table_64x16.mem";

    // One guidance step from the step source.
    typedef struct packed {
        logic [velocity_w-1:0]    velocity;
        logic signed [rate_w-1:0] pitch_rate;
    } step_t;

    // Per-step motion handed from the calculator to the integrator.
    typedef struct packed {
        logic [increment_w-1:0] dz;
        logic [increment_w-1:0] dx;
        logic [pitch_w-1:0]     pitch;
    } increment_t;

    // One integrated step.
    typedef struct packed {
        logic [pos_w-1:0]   altitude;
        logic [pos_w-1:0]   distance;
        logic [pitch_w-1:0] pitch;
        logic               cutoff;
    } result_t;

endpackage

`default_nettype wire

/* source/sine_lookup.sv */
`default_nettype none

module sine_lookup (
    input  logic                                   clk,
    input  logic [flight_pkg::table_depth_log2-1:0] sin_index,
    input  logic [flight_pkg::table_depth_log2-1:0] cos_index,
    output logic [flight_pkg::table_w-1:0]          sin_value,
    output logic [flight_pkg::table_w-1:0]          cos_value
);

    import flight_pkg::*;

    // Quarter wave, sampled at the middle of each of the 64 bins.
    logic [table_w-1:0] sine_rom [table_depth];

    initial begin
        $readmemh(sine_file, sine_rom);
    end

    // Two read ports, registered, so values follow the indices by one cycle.
    always_ff @(posedge clk) begin
        sin_value <= sine_rom[sin_index];
        cos_value <= sine_rom[cos_index];
    end

    // The calculator drives its indices from reset state onward.
    assert property (@(posedge clk) !$isunknown({sin_index, cos_index}))
        else $error("sine_lookup: unknown table index");

endmodule

`default_nettype wire

/* source/sine_table_64x16.mem */
// Entry k: sine of (k + 0.5) * 90 / 64 degrees, times 32767, in hex.
0192
04B6
07D9
0AFB
0E1C
113A
1455
176E
1A82
1D93
209F
23A6
26A8
29A3
2C99
2F87
326E
354D
3824
3AF2
3DB8
4073
4325
45CD
4869
4AFB
4D81
4FFB
5268
54C9
571D
5964
5B9C
5DC7
5FE3
61F0
63EE
65DD
67BC
698B
6B4A
6CF8
6E96
7022
719D
7307
745F
75A5
76D8
77FA
7909
7A05
7AEE
7BC5
7C88
7D38
7DD5
7E5F
7ED5
7F37
7F86
7FC1
7FE9
7FFD

/* source/trajectory_integrator.sv */
`default_nettype none

module trajectory_integrator (
    input  logic                   clk,
    input  logic                   resetb,
    input  logic                   launch,
    input  flight_pkg::increment_t increment,
    input  logic                   increment_valid,
    output logic                   step_ready,
    output flight_pkg::result_t    result,
    output logic                   result_valid
);

    import flight_pkg::*;

    logic [pos_w-1:0]   altitude_q;
    logic [pos_w-1:0]   distance_q;
    logic               cutoff_q;
    logic [pitch_w-1:0] pitch_q;
    logic [pos_w-1:0]   altitude_next;
    logic [pos_w-1:0]   distance_next;
    logic               take;

    // Once the target is reached, later increments are dropped.
    assign take = increment_valid && !cutoff_q;

    assign altitude_next = altitude_q + pos_w'(increment.dz);
    assign distance_next = distance_q + pos_w'(increment.dx);

    always_ff @(posedge clk or negedge resetb) begin
        if (!resetb) begin
            altitude_q <= '0;
            distance_q <= '0;
            cutoff_q <= 1'b0;
            result_valid <= 1'b0;
        end else if (launch) begin
            altitude_q <= '0;
            distance_q <= '0;
            cutoff_q <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= take;
            if (take) begin
                altitude_q <= altitude_next;
                distance_q <= distance_next;
                // The crossing step itself reports the cutoff.
                if (altitude_next >= target_altitude) begin
                    cutoff_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pitch_q <= increment.pitch;
        end
    end

    // Results come straight from the accumulators.
    assign result.altitude = altitude_q;
    assign result.distance = distance_q;
    assign result.pitch = pitch_q;
    assign result.cutoff = cutoff_q;

    assign step_ready = !cutoff_q;

    // Altitude only climbs within one flight.
    assert property (@(posedge clk) disable iff (!resetb)
        !launch |=> altitude_q >= $past(altitude_q))
        else $error("trajectory_integrator: altitude decreased");

endmodule

`default_nettype wire

/* tb/flight_checks.svh */
`ifndef FLIGHT_CHECKS_SVH
`define FLIGHT_CHECKS_SVH

// Model copy of the quarter-wave table.
logic [table_w-1:0] model_table [table_depth];

// Model state for the pitch register and the two position sums.
logic [pitch_w-1:0] model_pitch;
longint             model_alt;
longint             model_dist;
logic               model_cutoff;

// Expected results and the negedge count at which each must appear.
result_t exp_q[$];
int      due_q[$];

// Cycle from which step_ready is expected low, -1 while it stays high.
int      low_from;
int      ready_restore_at;
int      error_count;
logic    cutoff_seen;

initial begin
    $readmemh(sine_file, model_table);
    model_pitch = initial_pitch;
    model_alt = 0;
    model_dist = 0;
    model_cutoff = 1'b0;
    low_from = -1;
    ready_restore_at = -1;
    error_count = 0;
    cutoff_seen = 1'b0;
end

function automatic logic expect_ready(input int cycle);
    return (low_from < 0) || (cycle < low_from);
endfunction

// Applies one accepted step; the result is due four cycles later.
function automatic void model_accept(input step_t s, input int cycle);
    int      p;
    int      idx;
    longint  dz;
    longint  dx;
    result_t r;
    p = int'(model_pitch) - int'($signed(s.pitch_rate));
    if (p < 0) begin
        p = 0;
    end else if (p > 16383) begin
        p = 16383;
    end
    model_pitch = 14'(p);
    idx = p >> 8;
    dz = (longint'(s.velocity) * longint'(model_table[idx])) >> 15;
    dx = (longint'(s.velocity) * longint'(model_table[63 - idx])) >> 15;
    // Steps behind the crossing step are dropped by the integrator.
    if (!model_cutoff) begin
        model_alt = model_alt + dz;
        model_dist = model_dist + dx;
        if (model_alt >= longint'(target_altitude)) begin
            model_cutoff = 1'b1;
            low_from = cycle + 4;
        end
        r.altitude = 32'(model_alt);
        r.distance = 32'(model_dist);
        r.pitch = model_pitch;
        r.cutoff = model_cutoff;
        exp_q.push_back(r);
        due_q.push_back(cycle + 4);
    end
endfunction

function automatic void model_launch(input int cycle);
    model_pitch = initial_pitch;
    model_alt = 0;
    model_dist = 0;
    model_cutoff = 1'b0;
    while (due_q.size() > 0 && due_q[$] > cycle) begin
        void'(due_q.pop_back());
        void'(exp_q.pop_back());
    end
    if (low_from > cycle) begin
        low_from = -1;
    end else if (low_from >= 0) begin
        ready_restore_at = cycle + 1;
    end
endfunction

task automatic compare_result(input result_t expected, input result_t actual);
    if (actual !== expected) begin
        $write("ERROR at %0t: result expected alt=%0d dist=%0d pitch=%0d cutoff=%0b",
               $time, expected.altitude, expected.distance, expected.pitch,
               expected.cutoff);
        $display(", actual alt=%0d dist=%0d pitch=%0d cutoff=%0b",
                 actual.altitude, actual.distance, actual.pitch, actual.cutoff);
        error_count++;
    end
endtask

task automatic compare_ready(input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("ERROR at %0t: step_ready expected %0b, actual %0b",
                 $time, expected, actual);
        error_count++;
    end
endtask

`endif

/* tb/tb_flight_path.sv */
`default_nettype none

module tb_flight_path;

    import flight_pkg::*;

    localparam int reset_cycles = 10;
    localparam int first_cycles = 1;
    localparam int burst_cycles = 40;
    localparam int clamp_cycles = 12;
    localparam int cutoff_cycles = 12;
    localparam int relaunch_cycles = 20;
    localparam int gap_cycles = 60;
    localparam int drain_limit = 20;
    localparam int total_cycles = first_cycles + burst_cycles + clamp_cycles
                                + cutoff_cycles + relaunch_cycles + gap_cycles;

    logic    clk;
    logic    resetb;
    logic    launch;
    step_t   step;
    logic    step_valid;
    logic    step_ready;
    result_t result;
    logic    result_valid;

    int seed;
    int neg_count;
    int test_start_errors;
    int tests_run;
    int tests_failed;

    `include "flight_checks.svh"

    flight_path_top UUT (
        .clk          (clk),
        .resetb       (resetb),
        .launch       (launch),
        .step         (step),
        .step_valid   (step_valid),
        .step_ready   (step_ready),
        .result       (result),
        .result_valid (result_valid)
    );

    always #5 clk = ~clk;

    // Inputs settle after the rising edge, so the falling edge sees stable values.
    always @(negedge clk) begin
        neg_count++;
        if (resetb) begin
            check_cycle();
        end
    end

    task automatic check_cycle();
        result_t expected;
        if (neg_count == ready_restore_at) begin
            low_from = -1;
        end
        compare_ready(expect_ready(neg_count), step_ready);
        if (result_valid) begin
            if (result.cutoff) begin
                cutoff_seen = 1'b1;
            end
            if (due_q.size() == 0 || due_q[0] != neg_count) begin
                $display("At %0t a result_valid pulse arrived with no result expected.", $time);
                error_count++;
            end else begin
                expected = exp_q.pop_front();
                void'(due_q.pop_front());
                compare_result(expected, result);
            end
        end else if (due_q.size() > 0 && due_q[0] == neg_count) begin
            $display("At %0t an expected result did not arrive.", $time);
            error_count++;
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end
        if (launch) begin
            model_launch(neg_count);
        end else if (step_valid && expect_ready(neg_count)) begin
            model_accept(step, neg_count);
        end
    endtask

    task automatic drive_one(input logic [15:0] vel, input logic signed [13:0] rate,
                             input logic valid);
        @(posedge clk);
        step.velocity <= vel;
        step.pitch_rate <= rate;
        step_valid <= valid;
        launch <= 1'b0;
    endtask

    // One launch pulse with a step offered in the same cycle.
    task automatic pulse_launch(input logic [15:0] vel);
        @(posedge clk);
        launch <= 1'b1;
        step_valid <= 1'b1;
        step.velocity <= vel;
        step.pitch_rate <= 14'sd0;
    endtask

    task automatic drive_random(input int cycles, input int vel_base, input int vel_span,
                                input int rate_span, input int valid_pct);
        logic [15:0]        vel;
        logic signed [13:0] rate;
        logic               valid;
        repeat (cycles) begin
            vel = 16'(vel_base + int'($unsigned($random(seed)) % vel_span));
            rate = 14'($random(seed) % rate_span);
            valid = (int'($unsigned($random(seed)) % 100) < valid_pct);
            drive_one(vel, rate, valid);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        drive_one(16'd0, 14'sd0, 1'b0);
        while (exp_q.size() > 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Results were still pending after %0d cycles of drain.", drain_limit);
            error_count++;
        end
        @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count - test_start_errors;
        $display("%-12s done, %0d errors", name, errors);
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        test_start_errors = error_count;
    endtask

    initial begin
        #((reset_cycles + total_cycles * 10 + 200) * 10);
        $display("Watchdog expired before the tests finished.");
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        resetb = 1'b0;
        launch = 1'b0;
        step = '0;
        step_valid = 1'b0;
        seed = 32'h7663d885;
        neg_count = 0;
        test_start_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(posedge clk);
        resetb <= 1'b1;
        repeat (2) @(posedge clk);

        drive_one(16'd1000, 14'sd0, 1'b1);
        wait_drain();
        finish_test("after_reset");

        drive_random(burst_cycles, 100, 900, 64, 100);
        wait_drain();
        finish_test("back_to_back");

        // Drive the pitch to zero, then to full scale.
        repeat (clamp_cycles / 2) drive_one(16'd500, 14'sd8000, 1'b1);
        repeat (clamp_cycles / 2) drive_one(16'd500, -14'sd8000, 1'b1);
        wait_drain();
        finish_test("clamp");

        cutoff_seen = 1'b0;
        repeat (cutoff_cycles) drive_one(16'd60000, 14'sd0, 1'b1);
        wait_drain();
        if (!cutoff_seen) begin
            $display("No result with cutoff set arrived during the cutoff test.");
            error_count++;
        end
        finish_test("cutoff");

        // Launch after cutoff, then again while steps are in flight and ready is high.
        pulse_launch(16'd700);
        drive_random(relaunch_cycles / 2, 200, 800, 128, 100);
        pulse_launch(16'd900);
        drive_random(relaunch_cycles / 2, 200, 800, 128, 100);
        wait_drain();
        finish_test("launch");

        drive_random(gap_cycles, 100, 1000, 64, 50);
        wait_drain();
        finish_test("random_gaps");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
